// ==== Bender.yml ====
package:
  name: l1_mau

export_include_dirs:
  - include

sources:
  - hdl/l1_mau_pkg.sv
  - hdl/sync_fifo.sv
  - hdl/l1_req_arbiter.sv
  - hdl/wb_tr_engine.sv
  - hdl/wb_ack_collector.sv
  - hdl/l1_mau.sv
  - target: test
    files:
      - tests/wb_slave_model.sv
      - tests/tb_l1_mau.sv

// ==== hdl/l1_mau.sv ====
// L1 memory access unit
// Serves instruction line fills and data cache requests over a
// pipelined Wishbone B4 master port
`timescale 1ns/100ps
`include "l1_mau_config.svh"

module l1_mau (
	// Instruction cache
	input  logic                        l1i_req_val_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1i_req_addr_i,
	output logic                        l1i_req_ack_o,
	output logic [`L1_LINE_SIZE-1:0]    l1i_ack_data_o,
	// Data cache
	input  logic                        l1d_req_val_i,
	input  logic                        l1d_req_nc_i,
	input  logic                        l1d_req_we_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1d_req_addr_i,
	input  logic [`CORE_DATA_WIDTH-1:0] l1d_req_wdata_i,
	input  logic [`CORE_BE_WIDTH-1:0]   l1d_req_be_i,
	output logic                        l1d_req_ack_o,
	output logic [`L1_LINE_SIZE-1:0]    l1d_ack_data_o,
	output logic                        l1d_ack_nc_o,
	output logic                        l1d_ack_we_o,
	// Wishbone master
	input  logic                        wb_clk_i,
	input  logic                        wb_rst_i,
	input  logic [`CORE_DATA_WIDTH-1:0] wb_dat_i,
	input  logic                        wb_ack_i,
	input  logic                        wb_stall_i,
	output logic [`CORE_DATA_WIDTH-1:0] wb_dat_o,
	output logic [`CORE_ADDR_WIDTH-1:0] wb_adr_o,
	output logic [`CORE_BE_WIDTH-1:0]   wb_sel_o,
	output logic                        wb_cyc_o,
	output logic                        wb_stb_o,
	output logic                        wb_we_o
);

	l1_mau_pkg::mau_hdr_t        hdr_wr;
	l1_mau_pkg::mau_hdr_t        hdr_rd;
	l1_mau_pkg::mau_tag_t        tag_wr;
	l1_mau_pkg::mau_tag_t        tag_rd;
	l1_mau_pkg::mau_done_t       done;
	l1_mau_pkg::wb_mreq_t        mreq;
	logic                        grant;
	logic                        hdr_re;
	logic                        hdr_full;
	logic                        hdr_empty;
	logic                        dat_we;
	logic                        dat_re;
	logic                        dat_full;
	logic                        tag_re;
	logic                        tag_full;
	logic                        tag_empty;
	logic [`CORE_DATA_WIDTH-1:0] wdata_wr;
	logic [`CORE_DATA_WIDTH-1:0] wdata_rd;
	logic [`L1_LINE_SIZE-1:0]    line;

	l1_req_arbiter u_arbiter (
		.wb_clk_i        (wb_clk_i),
		.wb_rst_i        (wb_rst_i),
		.l1i_req_val_i   (l1i_req_val_i),
		.l1i_req_addr_i  (l1i_req_addr_i),
		.l1d_req_val_i   (l1d_req_val_i),
		.l1d_req_nc_i    (l1d_req_nc_i),
		.l1d_req_we_i    (l1d_req_we_i),
		.l1d_req_addr_i  (l1d_req_addr_i),
		.l1d_req_wdata_i (l1d_req_wdata_i),
		.l1d_req_be_i    (l1d_req_be_i),
		.hdr_full_i      (hdr_full),
		.dat_full_i      (dat_full),
		.tag_full_i      (tag_full),
		.done_i          (done),
		.grant_o         (grant),
		.hdr_o           (hdr_wr),
		.tag_o           (tag_wr),
		.dat_we_o        (dat_we),
		.wdata_o         (wdata_wr),
		.l1i_req_ack_o   (l1i_req_ack_o),
		.l1d_req_ack_o   (l1d_req_ack_o),
		.l1d_ack_nc_o    (l1d_ack_nc_o),
		.l1d_ack_we_o    (l1d_ack_we_o)
	);

	// ------------------------------
	// Queues between arbiter and bus
	// ------------------------------
	sync_fifo #(.DWIDTH($bits(l1_mau_pkg::mau_hdr_t)), .AWIDTH(2)) u_hdr_fifo (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.fifo_we_i    (grant),
		.fifo_wd_i    (hdr_wr),
		.fifo_re_i    (hdr_re),
		.fifo_rd_o    (hdr_rd),
		.fifo_full_o  (hdr_full),
		.fifo_empty_o (hdr_empty)
	);

	// Write data only, popped with its header
	sync_fifo #(.DWIDTH(`CORE_DATA_WIDTH), .AWIDTH(1)) u_dat_fifo (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.fifo_we_i    (dat_we),
		.fifo_wd_i    (wdata_wr),
		.fifo_re_i    (dat_re),
		.fifo_rd_o    (wdata_rd),
		.fifo_full_o  (dat_full),
		.fifo_empty_o ()
	);

	sync_fifo #(.DWIDTH($bits(l1_mau_pkg::mau_tag_t)), .AWIDTH(2)) u_tag_fifo (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.fifo_we_i    (grant),
		.fifo_wd_i    (tag_wr),
		.fifo_re_i    (tag_re),
		.fifo_rd_o    (tag_rd),
		.fifo_full_o  (tag_full),
		.fifo_empty_o (tag_empty)
	);

	wb_tr_engine u_tr_engine (
		.wb_clk_i    (wb_clk_i),
		.wb_rst_i    (wb_rst_i),
		.hdr_i       (hdr_rd),
		.hdr_empty_i (hdr_empty),
		.wdata_i     (wdata_rd),
		.wb_stall_i  (wb_stall_i),
		.hdr_re_o    (hdr_re),
		.dat_re_o    (dat_re),
		.wb_mreq_o   (mreq)
	);

	wb_ack_collector u_ack_collector (
		.wb_clk_i    (wb_clk_i),
		.wb_rst_i    (wb_rst_i),
		.wb_ack_i    (wb_ack_i),
		.wb_dat_i    (wb_dat_i),
		.tag_i       (tag_rd),
		.tag_empty_i (tag_empty),
		.tag_re_o    (tag_re),
		.wb_cyc_o    (wb_cyc_o),
		.line_o      (line),
		.done_o      (done)
	);

	assign wb_stb_o = mreq.stb;
	assign wb_we_o  = mreq.we;
	assign wb_sel_o = mreq.sel;
	assign wb_adr_o = mreq.adr;
	assign wb_dat_o = mreq.dat;

	// Both caches see the same line register
	assign l1i_ack_data_o = line;
	assign l1d_ack_data_o = line;

endmodule

// ==== hdl/l1_mau_pkg.sv ====
// Memory access unit types
// Request header, acknowledge tag, done report and Wishbone request
`include "l1_mau_config.svh"

package l1_mau_pkg;

	// One bus transaction as queued by the arbiter
	typedef struct packed {
		logic                        we;
		logic                        nc;
		logic [`CORE_BE_WIDTH-1:0]   be;
		logic [`CORE_ADDR_WIDTH-1:0] addr;
	} mau_hdr_t;

	// Expected acknowledge run, src 1 is the data cache
	typedef struct packed {
		logic                src;
		logic                we;
		logic                nc;
		logic [`TR_CNT_W-1:0] cnt;
	} mau_tag_t;

	// Completed read, back to the arbiter
	typedef struct packed {
		logic valid;
		logic src;
		logic nc;
	} mau_done_t;

	// Master request outputs of the Wishbone port
	typedef struct packed {
		logic                        stb;
		logic                        we;
		logic [`CORE_BE_WIDTH-1:0]   sel;
		logic [`CORE_ADDR_WIDTH-1:0] adr;
		logic [`CORE_DATA_WIDTH-1:0] dat;
	} wb_mreq_t;

endpackage

// ==== hdl/l1_req_arbiter.sv ====
// Request arbiter of the memory access unit
// Data cache over instruction cache, one read in flight per source,
// posted writes acknowledged on grant
`timescale 1ns/100ps
`include "l1_mau_config.svh"

module l1_req_arbiter (
	input  logic                        wb_clk_i,
	input  logic                        wb_rst_i,
	input  logic                        l1i_req_val_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1i_req_addr_i,
	input  logic                        l1d_req_val_i,
	input  logic                        l1d_req_nc_i,
	input  logic                        l1d_req_we_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1d_req_addr_i,
	input  logic [`CORE_DATA_WIDTH-1:0] l1d_req_wdata_i,
	input  logic [`CORE_BE_WIDTH-1:0]   l1d_req_be_i,
	input  logic                        hdr_full_i,
	input  logic                        dat_full_i,
	input  logic                        tag_full_i,
	input  l1_mau_pkg::mau_done_t       done_i,
	output logic                        grant_o,
	output l1_mau_pkg::mau_hdr_t        hdr_o,
	output l1_mau_pkg::mau_tag_t        tag_o,
	output logic                        dat_we_o,
	output logic [`CORE_DATA_WIDTH-1:0] wdata_o,
	output logic                        l1i_req_ack_o,
	output logic                        l1d_req_ack_o,
	output logic                        l1d_ack_nc_o,
	output logic                        l1d_ack_we_o
);

	localparam int BEATS = `L1_LINE_SIZE / `CORE_DATA_WIDTH;
	localparam logic [`CORE_ADDR_WIDTH-1:0] LINE_MASK =
		~(`CORE_ADDR_WIDTH'(`L1_LINE_SIZE / 8 - 1));

	logic                        room;
	logic                        d_sel;
	logic                        i_sel;
	logic                        wr_grant;
	logic                        single;
	logic                        d_busy_r;
	logic                        i_busy_r;
	logic [`CORE_ADDR_WIDTH-1:0] req_addr;

	// ------------------------------
	// Source selection
	// ------------------------------
	assign room     = !hdr_full_i && !tag_full_i;
	assign d_sel    = l1d_req_val_i && !d_busy_r && room && (!l1d_req_we_i || !dat_full_i);
	assign i_sel    = l1i_req_val_i && !i_busy_r && room && !d_sel;
	assign wr_grant = d_sel && l1d_req_we_i;
	assign single   = d_sel && (l1d_req_we_i || l1d_req_nc_i);
	assign req_addr = d_sel ? l1d_req_addr_i : l1i_req_addr_i;
	assign grant_o  = d_sel || i_sel;

	// Line fills start at the line base
	assign hdr_o.we   = wr_grant;
	assign hdr_o.nc   = d_sel && l1d_req_nc_i;
	assign hdr_o.be   = wr_grant ? l1d_req_be_i : '1;
	assign hdr_o.addr = single ? req_addr : (req_addr & LINE_MASK);

	assign tag_o.src = d_sel;
	assign tag_o.we  = wr_grant;
	assign tag_o.nc  = d_sel && l1d_req_nc_i;
	assign tag_o.cnt = single ? '0 : `TR_CNT_W'(BEATS - 1);

	assign dat_we_o = wr_grant;
	assign wdata_o  = l1d_req_wdata_i;

	// ------------------------------
	// Outstanding reads
	// ------------------------------
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			d_busy_r <= 1'b0;
			i_busy_r <= 1'b0;
		end else begin
			if (d_sel && !l1d_req_we_i)
				d_busy_r <= 1'b1;
			else if (done_i.valid && done_i.src)
				d_busy_r <= 1'b0;
			if (i_sel)
				i_busy_r <= 1'b1;
			else if (done_i.valid && !done_i.src)
				i_busy_r <= 1'b0;
		end
	end

	// Writes ack on grant, reads on their done pulse
	assign l1i_req_ack_o = done_i.valid && !done_i.src;
	assign l1d_req_ack_o = wr_grant || (done_i.valid && done_i.src);
	assign l1d_ack_nc_o  = (wr_grant && l1d_req_nc_i) || (done_i.valid && done_i.src && done_i.nc);
	assign l1d_ack_we_o  = wr_grant;

	// A cache keeps its request up until it is acknowledged
	a_i_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(l1i_req_val_i && !l1i_req_ack_o) |=> l1i_req_val_i);
	a_d_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(l1d_req_val_i && !l1d_req_ack_o) |=> l1d_req_val_i);
	// A done report always belongs to a read still in flight
	a_done_owned: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		done_i.valid |-> (done_i.src ? d_busy_r : i_busy_r));

endmodule

// ==== hdl/sync_fifo.sv ====
// Synchronous FIFO
// Register array with a show-ahead read port and full/empty flags
`timescale 1ns/100ps

module sync_fifo #(
	parameter int DWIDTH = 8,
	parameter int AWIDTH = 2
) (
	input  logic              wb_clk_i,
	input  logic              wb_rst_i,
	input  logic              fifo_we_i,
	input  logic [DWIDTH-1:0] fifo_wd_i,
	input  logic              fifo_re_i,
	output logic [DWIDTH-1:0] fifo_rd_o,
	output logic              fifo_full_o,
	output logic              fifo_empty_o
);

	localparam int DEPTH = 2 ** AWIDTH;

	logic [DWIDTH-1:0] mem_r [DEPTH];
	logic [AWIDTH:0]   wr_ptr_r;
	logic [AWIDTH:0]   rd_ptr_r;
	logic [AWIDTH:0]   count;

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
		end else begin
			if (fifo_we_i)
				wr_ptr_r <= wr_ptr_r + 1'b1;
			if (fifo_re_i)
				rd_ptr_r <= rd_ptr_r + 1'b1;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (fifo_we_i)
			mem_r[wr_ptr_r[AWIDTH-1:0]] <= fifo_wd_i;
	end

	// Head entry is visible without a read strobe
	assign fifo_rd_o    = mem_r[rd_ptr_r[AWIDTH-1:0]];
	assign count        = wr_ptr_r - rd_ptr_r;
	assign fifo_full_o  = (count == (AWIDTH+1)'(DEPTH));
	assign fifo_empty_o = (count == '0);

	a_no_overflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		fifo_we_i |-> !fifo_full_o);
	a_no_underflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		fifo_re_i |-> !fifo_empty_o);

endmodule

// ==== hdl/wb_ack_collector.sv ====
// Wishbone acknowledge collector
// Matches returning acks against queued tags, builds line data
// and reports completed reads
`timescale 1ns/100ps
`include "l1_mau_config.svh"

module wb_ack_collector (
	input  logic                        wb_clk_i,
	input  logic                        wb_rst_i,
	input  logic                        wb_ack_i,
	input  logic [`CORE_DATA_WIDTH-1:0] wb_dat_i,
	input  l1_mau_pkg::mau_tag_t        tag_i,
	input  logic                        tag_empty_i,
	output logic                        tag_re_o,
	output logic                        wb_cyc_o,
	output logic [`L1_LINE_SIZE-1:0]    line_o,
	output l1_mau_pkg::mau_done_t       done_o
);

	localparam logic ACK_IDLE = 1'b0;
	localparam logic ACK_REC  = 1'b1;

	logic                     state_r;
	logic                     state_nxt;
	logic [`TR_CNT_W-1:0]     cnt_r;
	logic [`TR_CNT_W-1:0]     cnt_nxt;
	logic                     last_ack;
	logic                     done_valid_r;
	logic                     done_src_r;
	logic                     done_nc_r;
	logic [`L1_LINE_SIZE-1:0] line_r;

	// First ack of a run is judged by the tag, later ones by the counter
	assign last_ack = wb_ack_i && ((state_r == ACK_IDLE) ? (tag_i.cnt == '0) : (cnt_r == '0));
	assign tag_re_o = last_ack;
	assign wb_cyc_o = !tag_empty_i;

	always_comb begin
		state_nxt = state_r;
		cnt_nxt   = cnt_r;
		if (last_ack) begin
			state_nxt = ACK_IDLE;
		end else if (wb_ack_i) begin
			state_nxt = ACK_REC;
			cnt_nxt   = ((state_r == ACK_IDLE) ? tag_i.cnt : cnt_r) - 1'b1;
		end
	end

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_r      <= ACK_IDLE;
			cnt_r        <= '0;
			done_valid_r <= 1'b0;
		end else begin
			state_r      <= state_nxt;
			cnt_r        <= cnt_nxt;
			done_valid_r <= last_ack && !tag_i.we;
		end
	end

	// ------------------------------
	// Line assembly
	// ------------------------------
	always_ff @(posedge wb_clk_i) begin
		if (wb_ack_i)
			line_r <= {wb_dat_i, line_r[`L1_LINE_SIZE-1:`CORE_DATA_WIDTH]};
		if (last_ack) begin
			done_src_r <= tag_i.src;
			done_nc_r  <= tag_i.nc;
		end
	end

	assign line_o = line_r;
	assign done_o = '{valid: done_valid_r, src: done_src_r, nc: done_nc_r};

	a_ack_expected: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_i |-> !tag_empty_i);

endmodule

// ==== hdl/wb_tr_engine.sv ====
// Wishbone transaction engine
// Turns queued headers into pipelined strobes, one beat per unstalled cycle
`timescale 1ns/100ps
`include "l1_mau_config.svh"

module wb_tr_engine (
	input  logic                        wb_clk_i,
	input  logic                        wb_rst_i,
	input  l1_mau_pkg::mau_hdr_t        hdr_i,
	input  logic                        hdr_empty_i,
	input  logic [`CORE_DATA_WIDTH-1:0] wdata_i,
	input  logic                        wb_stall_i,
	output logic                        hdr_re_o,
	output logic                        dat_re_o,
	output l1_mau_pkg::wb_mreq_t        wb_mreq_o
);

	localparam int   BEATS   = `L1_LINE_SIZE / `CORE_DATA_WIDTH;
	localparam logic TR_IDLE = 1'b0;
	localparam logic TR_REQ  = 1'b1;

	logic                        state_r;
	logic                        state_nxt;
	logic [`CORE_ADDR_WIDTH-1:0] addr_r;
	logic [`CORE_ADDR_WIDTH-1:0] addr_nxt;
	logic [`TR_CNT_W-1:0]        cnt_r;
	logic [`TR_CNT_W-1:0]        cnt_nxt;
	logic                        last_beat;

	assign last_beat = (state_r == TR_REQ) && (cnt_r == '0) && !wb_stall_i;
	assign hdr_re_o  = last_beat;
	assign dat_re_o  = last_beat && hdr_i.we;

	always_comb begin
		state_nxt = state_r;
		addr_nxt  = addr_r;
		cnt_nxt   = cnt_r;
		if (state_r == TR_IDLE) begin
			if (!hdr_empty_i) begin
				state_nxt = TR_REQ;
				addr_nxt  = hdr_i.addr;
				cnt_nxt   = (hdr_i.we || hdr_i.nc) ? '0 : `TR_CNT_W'(BEATS - 1);
			end
		end else if (!wb_stall_i) begin
			if (cnt_r == '0) begin
				state_nxt = TR_IDLE;
			end else begin
				addr_nxt = addr_r + `CORE_ADDR_WIDTH'(`CORE_DATA_WIDTH / 8);
				cnt_nxt  = cnt_r - 1'b1;
			end
		end
	end

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_r <= TR_IDLE;
			cnt_r   <= '0;
		end else begin
			state_r <= state_nxt;
			cnt_r   <= cnt_nxt;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		addr_r <= addr_nxt;
	end

	// we, sel and dat come from FIFO heads, held until the last beat pops them
	assign wb_mreq_o = '{stb: (state_r == TR_REQ), we: hdr_i.we, sel: hdr_i.be,
		adr: addr_r, dat: wdata_i};

	a_stall_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(wb_mreq_o.stb && wb_stall_i) |=> (wb_mreq_o.stb && $stable(wb_mreq_o.adr)));

endmodule

// ==== include/l1_mau_config.svh ====
// Memory access unit configuration
// Widths of the core address, bus beat, byte enables and cache line
`ifndef L1_MAU_CONFIG_SVH
`define L1_MAU_CONFIG_SVH

// Core side
`define CORE_ADDR_WIDTH 32
`define CORE_DATA_WIDTH 32
`define CORE_BE_WIDTH   4

// One line is four bus beats
`define L1_LINE_SIZE    128
`define TR_CNT_W        2

`endif

// ==== l1_mau.f ====
+incdir+include
hdl/l1_mau_pkg.sv
hdl/sync_fifo.sv
hdl/l1_req_arbiter.sv
hdl/wb_tr_engine.sv
hdl/wb_ack_collector.sv
hdl/l1_mau.sv
tests/wb_slave_model.sv
tests/tb_l1_mau.sv

// ==== tests/tb_l1_mau.sv ====
// Testbench for the L1 memory access unit
// Line fills, uncached reads, posted writes and arbitration against a
// stalling Wishbone slave, checked by concurrent assertions
`timescale 1ns/100ps
`include "l1_mau_config.svh"

module tb_l1_mau;

	localparam int TIMEOUT = 200;

	logic                        wb_clk;
	logic                        wb_rst;
	logic                        l1i_req_val;
	logic [`CORE_ADDR_WIDTH-1:0] l1i_req_addr;
	logic                        l1i_req_ack;
	logic [`L1_LINE_SIZE-1:0]    l1i_ack_data;
	logic                        l1d_req_val;
	logic                        l1d_req_nc;
	logic                        l1d_req_we;
	logic [`CORE_ADDR_WIDTH-1:0] l1d_req_addr;
	logic [`CORE_DATA_WIDTH-1:0] l1d_req_wdata;
	logic [`CORE_BE_WIDTH-1:0]   l1d_req_be;
	logic                        l1d_req_ack;
	logic [`L1_LINE_SIZE-1:0]    l1d_ack_data;
	logic                        l1d_ack_nc;
	logic                        l1d_ack_we;
	logic [`CORE_DATA_WIDTH-1:0] wb_rdat;
	logic [`CORE_DATA_WIDTH-1:0] wb_wdat;
	logic [`CORE_ADDR_WIDTH-1:0] wb_adr;
	logic [`CORE_BE_WIDTH-1:0]   wb_sel;
	logic                        wb_cyc;
	logic                        wb_stb;
	logic                        wb_we;
	logic                        wb_ack;
	logic                        wb_stall;
	logic                        stall_en;
	logic                        stall_rnd;
	logic [1:0]                  ack_lat;
	logic [31:0]                 lfsr_r;
	logic [`CORE_DATA_WIDTH-1:0] ref_mem [1024];
	logic [`L1_LINE_SIZE-1:0]    exp_i_line;
	logic [`L1_LINE_SIZE-1:0]    exp_d_line;
	logic                        exp_d_nc;
	logic                        i_ack_q;
	logic                        d_ack_q;
	logic                        beat_acc;
	logic [1:0]                  burst_left;
	logic [`CORE_ADDR_WIDTH-1:0] burst_adr;
	logic                        race_pend;
	logic [`CORE_ADDR_WIDTH-1:0] race_adr;
	int                          error_count;
	int                          test_count;
	int                          test_fail;
	int                          test_err0;

	initial wb_clk = 1'b0;
	always #50 wb_clk = ~wb_clk;

	l1_mau l1_mau_inst (
		.l1i_req_val_i   (l1i_req_val),
		.l1i_req_addr_i  (l1i_req_addr),
		.l1i_req_ack_o   (l1i_req_ack),
		.l1i_ack_data_o  (l1i_ack_data),
		.l1d_req_val_i   (l1d_req_val),
		.l1d_req_nc_i    (l1d_req_nc),
		.l1d_req_we_i    (l1d_req_we),
		.l1d_req_addr_i  (l1d_req_addr),
		.l1d_req_wdata_i (l1d_req_wdata),
		.l1d_req_be_i    (l1d_req_be),
		.l1d_req_ack_o   (l1d_req_ack),
		.l1d_ack_data_o  (l1d_ack_data),
		.l1d_ack_nc_o    (l1d_ack_nc),
		.l1d_ack_we_o    (l1d_ack_we),
		.wb_clk_i        (wb_clk),
		.wb_rst_i        (wb_rst),
		.wb_dat_i        (wb_rdat),
		.wb_ack_i        (wb_ack),
		.wb_stall_i      (wb_stall),
		.wb_dat_o        (wb_wdat),
		.wb_adr_o        (wb_adr),
		.wb_sel_o        (wb_sel),
		.wb_cyc_o        (wb_cyc),
		.wb_stb_o        (wb_stb),
		.wb_we_o         (wb_we)
	);

	wb_slave_model u_slave (
		.wb_clk_i    (wb_clk),
		.wb_rst_i    (wb_rst),
		.wb_cyc_i    (wb_cyc),
		.wb_stb_i    (wb_stb),
		.wb_we_i     (wb_we),
		.wb_sel_i    (wb_sel),
		.wb_adr_i    (wb_adr),
		.wb_dat_i    (wb_wdat),
		.stall_en_i  (stall_en),
		.stall_rnd_i (stall_rnd),
		.ack_lat_i   (ack_lat),
		.wb_stall_o  (wb_stall),
		.wb_ack_o    (wb_ack),
		.wb_dat_o    (wb_rdat)
	);

	// ------------------------------
	// Random bus behavior
	// ------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [3:0] bits);
		bits = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_r  = lfsr_next(lfsr_r);
			bits[k] = lfsr_r[0];
		end
	endtask

	always @(negedge wb_clk) begin
		logic [3:0] bits;
		take_bits(3, bits);
		stall_rnd = bits[0];
		ack_lat   = (bits[2:1] == 2'd3) ? 2'd2 : bits[2:1];
	end

	// ------------------------------
	// Bus monitor
	// ------------------------------
	assign beat_acc = wb_cyc && wb_stb && !wb_stall;

	// Uncached reads never use a line-aligned address, so an aligned read starts a line
	always @(posedge wb_clk or posedge wb_rst) begin
		if (wb_rst) begin
			burst_left <= '0;
		end else if (beat_acc) begin
			if (burst_left != 0) begin
				burst_left <= burst_left - 1'b1;
				burst_adr  <= burst_adr + 32'd4;
			end else if (!wb_we && wb_adr[3:0] == 4'h0) begin
				burst_left <= 2'd3;
				burst_adr  <= wb_adr + 32'd4;
			end
		end
		if (race_pend && wb_stb)
			race_pend <= 1'b0;
	end

	always @(posedge wb_clk) begin
		i_ack_q <= l1i_req_ack;
		d_ack_q <= l1d_req_ack;
	end

	// ------------------------------
	// Reporting and reference model
	// ------------------------------
	task automatic flag_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		error_count++;
		$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
	endtask

	task automatic flag_event(input string msg);
		error_count++;
		$display("Check failed: %s", msg);
	endtask

	function automatic logic [31:0] ref_word(input logic [31:0] addr);
		return ref_mem[addr[11:2]];
	endfunction

	// Beat 0 in the low word
	function automatic logic [127:0] ref_line(input logic [31:0] addr);
		logic [31:0] base;
		base = addr & ~32'hf;
		return {ref_word(base + 12), ref_word(base + 8), ref_word(base + 4), ref_word(base)};
	endfunction

	// ------------------------------
	// Checks
	// ------------------------------
	a_reset_quiet: assert property (@(posedge wb_clk) $fell(wb_rst) |->
		!(wb_cyc || wb_stb || l1i_req_ack || l1d_req_ack || l1d_ack_nc || l1d_ack_we))
		else flag_event("outputs active right after reset");
	a_i_line: assert property (@(posedge wb_clk) disable iff (wb_rst)
		l1i_req_ack |-> (l1i_ack_data == exp_i_line))
		else flag_value("l1i_ack_data_o", $sampled(l1i_ack_data), exp_i_line);
	a_d_line: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(l1d_req_ack && !l1d_ack_we && !exp_d_nc) |-> (l1d_ack_data == exp_d_line))
		else flag_value("l1d_ack_data_o", $sampled(l1d_ack_data), exp_d_line);
	a_d_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(l1d_req_ack && !l1d_ack_we && exp_d_nc) |-> (l1d_ack_data[127:96] == exp_d_line[127:96]))
		else flag_value("l1d_ack_data_o", $sampled(l1d_ack_data[127:96]), exp_d_line[127:96]);
	a_d_nc_flag: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(l1d_req_ack && !l1d_ack_we) |-> (l1d_ack_nc == exp_d_nc))
		else flag_value("l1d_ack_nc_o", $sampled(l1d_ack_nc), exp_d_nc);
	a_write_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(l1d_req_val && l1d_req_we && l1d_req_ack) |-> l1d_ack_we)
		else flag_event("write acknowledged without l1d_ack_we_o");
	a_write_only: assert property (@(posedge wb_clk) disable iff (wb_rst)
		l1d_ack_we |-> (l1d_req_val && l1d_req_we && l1d_req_ack))
		else flag_event("l1d_ack_we_o high without an accepted write");
	a_ack_owned: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(l1i_req_ack |-> l1i_req_val) and (l1d_req_ack |-> l1d_req_val))
		else flag_event("ack returned to a cache with no request");
	a_stall_hold: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(wb_stb && wb_stall) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we) &&
		$stable(wb_sel) && $stable(wb_wdat)))
		else flag_event("bus request changed while stalled");
	a_line_step: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(beat_acc && burst_left != 0) |-> (wb_adr == burst_adr && !wb_we))
		else flag_value("wb_adr_o", $sampled(wb_adr), burst_adr);
	a_line_gapless: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(burst_left != 0) |-> wb_stb)
		else flag_event("strobe dropped inside a line burst");
	a_data_first: assert property (@(posedge wb_clk) disable iff (wb_rst)
		(race_pend && wb_stb) |-> (wb_adr == race_adr))
		else flag_value("wb_adr_o", $sampled(wb_adr), race_adr);

	// ------------------------------
	// Stimulus tasks
	// ------------------------------
	task automatic ifill(input logic [31:0] addr);
		int waited;
		exp_i_line   = ref_line(addr);
		l1i_req_addr = addr;
		l1i_req_val  = 1'b1;
		waited       = 0;
		do begin
			@(negedge wb_clk);
			waited++;
		end while (!i_ack_q && waited < TIMEOUT);
		if (!i_ack_q)
			flag_event("instruction cache ack did not arrive");
		l1i_req_val = 1'b0;
	endtask

	task automatic dread(input logic [31:0] addr, input logic nc);
		int waited;
		exp_d_nc     = nc;
		exp_d_line   = nc ? {ref_word(addr), 96'h0} : ref_line(addr);
		l1d_req_addr = addr;
		l1d_req_nc   = nc;
		l1d_req_we   = 1'b0;
		l1d_req_val  = 1'b1;
		waited       = 0;
		do begin
			@(negedge wb_clk);
			waited++;
		end while (!d_ack_q && waited < TIMEOUT);
		if (!d_ack_q)
			flag_event("data cache read ack did not arrive");
		l1d_req_val = 1'b0;
	endtask

	task automatic dwrite(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		int waited;
		l1d_req_addr  = addr;
		l1d_req_wdata = data;
		l1d_req_be    = be;
		l1d_req_nc    = 1'b0;
		l1d_req_we    = 1'b1;
		l1d_req_val   = 1'b1;
		waited        = 0;
		do begin
			@(negedge wb_clk);
			waited++;
		end while (!d_ack_q && waited < TIMEOUT);
		if (!d_ack_q) begin
			flag_event("data cache write ack did not arrive");
		end else begin
			for (int b = 0; b < 4; b++)
				if (be[b])
					ref_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
		end
		l1d_req_val = 1'b0;
		l1d_req_we  = 1'b0;
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		do begin
			@(negedge wb_clk);
			waited++;
		end while (wb_cyc && waited < TIMEOUT);
		if (wb_cyc)
			flag_event("bus did not go idle");
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count != test_err0) begin
			test_fail++;
			$display("Test %0d %s: failed", test_count, name);
		end else begin
			$display("Test %0d %s: passed", test_count, name);
		end
		test_err0 = error_count;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		wb_rst        = 1'b1;
		l1i_req_val   = 1'b0;
		l1i_req_addr  = '0;
		l1d_req_val   = 1'b0;
		l1d_req_nc    = 1'b0;
		l1d_req_we    = 1'b0;
		l1d_req_addr  = '0;
		l1d_req_wdata = '0;
		l1d_req_be    = '0;
		stall_en      = 1'b0;
		stall_rnd     = 1'b0;
		ack_lat       = 2'd0;
		race_pend     = 1'b0;
		race_adr      = '0;
		exp_i_line    = '0;
		exp_d_line    = '0;
		exp_d_nc      = 1'b0;
		lfsr_r        = 32'h3b15_4abb;
		error_count   = 0;
		test_count    = 0;
		test_fail     = 0;
		test_err0     = 0;
		for (int k = 0; k < 1024; k++)
			ref_mem[k] = 32'(k * 4) ^ 32'h5a5a_0000;

		repeat (5) @(negedge wb_clk);
		wb_rst = 1'b0;
		repeat (2) @(negedge wb_clk);
		end_test("reset state");

		ifill(32'h0000_0108);
		end_test("instruction line fill");

		dread(32'h0000_0204, 1'b0);
		dread(32'h0000_0304, 1'b1);
		end_test("data line and uncached read");

		dwrite(32'h0000_0208, 32'ha1b2_c3d4, 4'b0101);
		dwrite(32'h0000_020c, 32'h1122_3344, 4'b1110);
		dread(32'h0000_0200, 1'b0);
		end_test("posted write merge");

		wait_idle();
		race_adr  = 32'h0000_0500;
		race_pend = 1'b1;
		fork
			ifill(32'h0000_0404);
			dread(32'h0000_0508, 1'b0);
		join
		end_test("same cycle arbitration");

		// Instruction lines and data lines live in separate regions
		stall_en = 1'b1;
		for (int n = 0; n < 8; n++) begin
			fork
				ifill(32'h0000_0800 + n * 32'h44);
				begin
					dwrite(32'h0000_0c04 + n * 32'h40, 32'hc0de_0000 + n, 4'b1001);
					dread(32'h0000_0c00 + n * 32'h40 + (n % 4) * 4, n[0]);
				end
			join
		end
		wait_idle();
		stall_en = 1'b0;
		end_test("random stall");

		$display("Tests run %0d, failed %0d, errors %0d", test_count, test_fail, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Guard against a stuck run
	initial begin
		#1_000_000;
		$display("Simulation watchdog expired");
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== tests/wb_slave_model.sv ====
// Pipelined Wishbone slave model
// Word memory, in-order responses with random latency and stall
`timescale 1ns/100ps
`include "l1_mau_config.svh"

module wb_slave_model #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                        wb_clk_i,
	input  logic                        wb_rst_i,
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  logic [`CORE_BE_WIDTH-1:0]   wb_sel_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] wb_adr_i,
	input  logic [`CORE_DATA_WIDTH-1:0] wb_dat_i,
	input  logic                        stall_en_i,
	input  logic                        stall_rnd_i,
	input  logic [1:0]                  ack_lat_i,
	output logic                        wb_stall_o,
	output logic                        wb_ack_o,
	output logic [`CORE_DATA_WIDTH-1:0] wb_dat_o
);

	logic [`CORE_DATA_WIDTH-1:0] mem_r [MEM_WORDS];
	logic [`CORE_DATA_WIDTH-1:0] rsp_dat_q [$];
	int unsigned                 rsp_due_q [$];
	int unsigned                 cycle_r;

	assign wb_stall_o = stall_en_i && stall_rnd_i;

	initial begin
		for (int k = 0; k < MEM_WORDS; k++)
			mem_r[k] = 32'(k * 4) ^ 32'h5a5a_0000;
		cycle_r  = 0;
		wb_ack_o = 1'b0;
		wb_dat_o = '0;
	end

	// Accept a beat and queue its response
	always @(posedge wb_clk_i) begin
		int unsigned idx;
		cycle_r = cycle_r + 1;
		if (!wb_rst_i && wb_cyc_i && wb_stb_i && !wb_stall_o) begin
			idx = (wb_adr_i >> 2) % MEM_WORDS;
			if (wb_we_i) begin
				for (int b = 0; b < `CORE_BE_WIDTH; b++)
					if (wb_sel_i[b])
						mem_r[idx][8*b +: 8] = wb_dat_i[8*b +: 8];
			end
			rsp_dat_q.push_back(mem_r[idx]);
			rsp_due_q.push_back(cycle_r + ack_lat_i);
		end
	end

	// At most one ack per cycle, oldest first
	always @(negedge wb_clk_i) begin
		if (wb_rst_i) begin
			rsp_dat_q.delete();
			rsp_due_q.delete();
			wb_ack_o <= 1'b0;
		end else if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle_r) begin
			wb_ack_o <= 1'b1;
			wb_dat_o <= rsp_dat_q.pop_front();
			void'(rsp_due_q.pop_front());
		end else begin
			wb_ack_o <= 1'b0;
		end
	end

endmodule
